//--- filelist.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/mipsDecode.sv
verilog/mipsExecute.sv
verilog/mipsResult.sv
verilog/mipsCore.sv
verif/wbMemoryModel.sv
verif/mipsCoreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module mipsCoreTb -Mdir "$buildDir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VmipsCoreTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Finished with no errors$" "$logFile"; then
    exit 0
fi
exit 1

//--- verif/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

    localparam int clkPeriod      = 40;
    localparam int resetCycles    = 3;
    localparam int entryCount     = 32;
    localparam int watchdogCycles = entryCount * 20 + resetCycles;

    localparam logic [5:0] opcAddiu = 6'h09;
    localparam logic [5:0] opcOri   = 6'h0d;
    localparam logic [5:0] opcLui   = 6'h0f;
    localparam logic [5:0] opcLw    = 6'h23;
    localparam logic [5:0] opcSw    = 6'h2b;
    localparam logic [5:0] fnAddu   = 6'h21;
    localparam logic [5:0] fnSubu   = 6'h23;
    localparam logic [5:0] fnAnd    = 6'h24;
    localparam logic [5:0] fnOr     = 6'h25;
    localparam logic [5:0] fnXor    = 6'h26;
    localparam logic [5:0] fnSlt    = 6'h2a;
    localparam logic [5:0] fnSll    = 6'h00;
    localparam logic [5:0] fnSrl    = 6'h02;

    typedef struct packed {
        mipsPkg::instrWord instr;
        logic              writes;
        mipsPkg::regIndex  destReg;
        mipsPkg::dataWord  value;
    } stimEntry;

    logic              CLK;
    logic              reset;
    logic              instrValid;
    mipsPkg::instrWord instr;
    logic              instrReady;
    logic              wbCyc;
    logic              wbStb;
    logic              wbWe;
    mipsPkg::dataWord  wbAdr;
    mipsPkg::dataWord  wbDatO;
    logic [3:0]        wbSel;
    mipsPkg::dataWord  wbDatI;
    logic              wbAck;
    logic              retireValid;
    mipsPkg::regIndex  retireReg;
    mipsPkg::dataWord  retireData;

    stimEntry stimTable [entryCount];
    string    entryName [entryCount];
    int       expectIdx [$];
    int       rowCount;
    int       nextIdx;
    int       expectedRetires;
    int       retireCount;
    int       testCount;
    int       errorCount;

    mipsCore mipsCore_inst (
        .CLK         (CLK),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatO      (wbDatO),
        .wbSel       (wbSel),
        .wbDatI      (wbDatI),
        .wbAck       (wbAck),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    wbMemoryModel wbMemoryModel_inst (
        .CLK    (CLK),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbSel  (wbSel),
        .wbDatI (wbDatI),
        .wbAck  (wbAck)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    // ------------------------------
    // Encoders and compare tasks
    // ------------------------------
    function automatic mipsPkg::instrWord encodeR(logic [5:0] funct, mipsPkg::regIndex rs,
            mipsPkg::regIndex rt, mipsPkg::regIndex rd, mipsPkg::shiftAmount sa);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic mipsPkg::instrWord encodeI(logic [5:0] opcode, mipsPkg::regIndex rs,
            mipsPkg::regIndex rt, logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic mipsPkg::dataWord peekMemory(mipsPkg::dataWord addr);
        return wbMemoryModel_inst.memory[addr[9:2]];
    endfunction

    // Rows writing r0 are kept in the table but expect no retire report
    task automatic addEntry(input string name, input mipsPkg::instrWord word,
            input logic doesWrite, input mipsPkg::regIndex dest, input mipsPkg::dataWord value);
        stimTable[rowCount] = '{instr: word, writes: doesWrite, destReg: dest, value: value};
        entryName[rowCount] = name;
        if (stimTable[rowCount].writes && dest != '0) begin
            expectIdx.push_back(rowCount);
        end
        rowCount++;
    endtask

    task automatic checkRetire(input mipsPkg::regIndex gotReg, input mipsPkg::dataWord gotData,
            input mipsPkg::regIndex wantReg, input mipsPkg::dataWord wantData, input string name);
        testCount++;
        if (gotReg !== wantReg || gotData !== wantData) begin
            errorCount++;
            $display("Mismatch at %0t: %s retired r%0d = %h, expected r%0d = %h",
                     $time, name, gotReg, gotData, wantReg, wantData);
        end else begin
            $display("ok   %s  r%0d = %h", name, gotReg, gotData);
        end
    endtask

    task automatic checkWord(input mipsPkg::dataWord got, input mipsPkg::dataWord want,
            input string name);
        testCount++;
        if (got !== want) begin
            errorCount++;
            $display("Mismatch at %0t: %s holds %h, expected %h", $time, name, got, want);
        end else begin
            $display("ok   %s = %h", name, got);
        end
    endtask

    task automatic buildTable();
        // ALU operations
        addEntry("addiu r1", encodeI(opcAddiu, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h0000_0005);
        addEntry("addiu r2", encodeI(opcAddiu, 5'd0, 5'd2, 16'hFFFD), 1'b1, 5'd2, 32'hFFFF_FFFD);
        addEntry("ori r3", encodeI(opcOri, 5'd0, 5'd3, 16'h8001), 1'b1, 5'd3, 32'h0000_8001);
        addEntry("lui r4", encodeI(opcLui, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h1234_0000);
        addEntry("addu r5", encodeR(fnAddu, 5'd4, 5'd3, 5'd5, 5'd0), 1'b1, 5'd5, 32'h1234_8001);
        addEntry("subu r6", encodeR(fnSubu, 5'd1, 5'd2, 5'd6, 5'd0), 1'b1, 5'd6, 32'h0000_0008);
        addEntry("and r7", encodeR(fnAnd, 5'd5, 5'd3, 5'd7, 5'd0), 1'b1, 5'd7, 32'h0000_8001);
        addEntry("or r8", encodeR(fnOr, 5'd4, 5'd1, 5'd8, 5'd0), 1'b1, 5'd8, 32'h1234_0005);
        addEntry("xor r9", encodeR(fnXor, 5'd5, 5'd4, 5'd9, 5'd0), 1'b1, 5'd9, 32'h0000_8001);
        addEntry("slt r10 neg", encodeR(fnSlt, 5'd2, 5'd1, 5'd10, 5'd0), 1'b1, 5'd10, 32'h1);
        addEntry("slt r11", encodeR(fnSlt, 5'd1, 5'd2, 5'd11, 5'd0), 1'b1, 5'd11, 32'h0);
        addEntry("sll r12", encodeR(fnSll, 5'd0, 5'd1, 5'd12, 5'd4), 1'b1, 5'd12, 32'h0000_0050);
        addEntry("srl r13", encodeR(fnSrl, 5'd0, 5'd4, 5'd13, 5'd8), 1'b1, 5'd13, 32'h0012_3400);
        // Dependent chain through the scoreboard
        addEntry("chain r14 a", encodeI(opcAddiu, 5'd0, 5'd14, 16'h0001), 1'b1, 5'd14, 32'h1);
        addEntry("chain r14 b", encodeR(fnAddu, 5'd14, 5'd14, 5'd14, 5'd0), 1'b1, 5'd14, 32'h2);
        addEntry("chain r14 c", encodeR(fnAddu, 5'd14, 5'd14, 5'd14, 5'd0), 1'b1, 5'd14, 32'h4);
        addEntry("chain r15", encodeR(fnSll, 5'd0, 5'd14, 5'd15, 5'd3), 1'b1, 5'd15, 32'h20);
        addEntry("chain r16", encodeR(fnSubu, 5'd15, 5'd14, 5'd16, 5'd0), 1'b1, 5'd16, 32'h1C);
        // Register 0
        addEntry("addiu r0", encodeI(opcAddiu, 5'd0, 5'd0, 16'h0077), 1'b1, 5'd0, 32'h77);
        addEntry("addu r17 from r0", encodeR(fnAddu, 5'd0, 5'd1, 5'd17, 5'd0), 1'b1, 5'd17,
                 32'h5);
        // Store then load
        addEntry("base r18", encodeI(opcAddiu, 5'd0, 5'd18, 16'h0040), 1'b1, 5'd18, 32'h40);
        addEntry("sw r5", encodeI(opcSw, 5'd18, 5'd5, 16'h0000), 1'b0, 5'd0, 32'h0);
        addEntry("sw r13", encodeI(opcSw, 5'd18, 5'd13, 16'h0004), 1'b0, 5'd0, 32'h0);
        addEntry("lw r19", encodeI(opcLw, 5'd18, 5'd19, 16'h0000), 1'b1, 5'd19, 32'h1234_8001);
        addEntry("lw r20", encodeI(opcLw, 5'd18, 5'd20, 16'h0004), 1'b1, 5'd20, 32'h0012_3400);
        // Work queued behind slow loads
        addEntry("lw r21", encodeI(opcLw, 5'd18, 5'd21, 16'h0000), 1'b1, 5'd21, 32'h1234_8001);
        addEntry("ori r22", encodeI(opcOri, 5'd1, 5'd22, 16'h00F0), 1'b1, 5'd22, 32'h0000_00F5);
        addEntry("addu r23", encodeR(fnAddu, 5'd22, 5'd21, 5'd23, 5'd0), 1'b1, 5'd23,
                 32'h1234_80F6);
        addEntry("xor r24", encodeR(fnXor, 5'd23, 5'd22, 5'd24, 5'd0), 1'b1, 5'd24,
                 32'h1234_8003);
        addEntry("sw r24", encodeI(opcSw, 5'd18, 5'd24, 16'h0008), 1'b0, 5'd0, 32'h0);
        addEntry("lw r25", encodeI(opcLw, 5'd18, 5'd25, 16'h0008), 1'b1, 5'd25, 32'h1234_8003);
        addEntry("addiu r26", encodeI(opcAddiu, 5'd25, 5'd26, 16'hFFFF), 1'b1, 5'd26,
                 32'h1234_8002);
    endtask

    // ------------------------------
    // Retire monitor
    // ------------------------------
    always @(negedge CLK) begin
        if (!reset && retireValid) begin
            if (expectIdx.size() == 0) begin
                errorCount++;
                $display("Unexpected retire report for r%0d at %0t after all expected ones",
                         retireReg, $time);
            end else begin
                nextIdx = expectIdx.pop_front();
                checkRetire(retireReg, retireData, stimTable[nextIdx].destReg,
                            stimTable[nextIdx].value, entryName[nextIdx]);
            end
            retireCount++;
        end
    end

    // Stops a run whose pipeline never drains
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Run timed out after %0d cycles without draining", watchdogCycles);
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        rowCount    = 0;
        retireCount = 0;
        testCount   = 0;
        errorCount  = 0;
        buildTable();
        expectedRetires = expectIdx.size();
        if (rowCount != entryCount) begin
            errorCount++;
            $display("Stimulus table holds %0d rows instead of %0d", rowCount, entryCount);
        end

        repeat (resetCycles) @(posedge CLK);
        reset <= 1'b0;

        for (int i = 0; i < rowCount; i++) begin
            instrValid <= 1'b1;
            instr      <= stimTable[i].instr;
            // Ready is settled by mid cycle
            @(negedge CLK);
            while (!instrReady) begin
                @(negedge CLK);
            end
            @(posedge CLK);
        end
        instrValid <= 1'b0;

        while (retireCount < expectedRetires) begin
            @(posedge CLK);
        end
        while (wbCyc) begin
            @(posedge CLK);
        end
        // Room for any stray report
        repeat (4) @(posedge CLK);

        testCount++;
        if (retireCount != expectedRetires) begin
            errorCount++;
            $display("Mismatch at %0t: %0d retire reports, expected %0d",
                     $time, retireCount, expectedRetires);
        end else begin
            $display("ok   retire count = %0d", retireCount);
        end
        checkWord(peekMemory(32'h40), 32'h1234_8001, "memory 0x40");
        checkWord(peekMemory(32'h44), 32'h0012_3400, "memory 0x44");
        checkWord(peekMemory(32'h48), 32'h1234_8003, "memory 0x48");

        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verif/wbMemoryModel.sv
`timescale 1ns/1ps

// Wishbone classic slave; port names follow the bus nets of mipsCore
module wbMemoryModel (
    input  logic             CLK,
    input  logic             reset,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic             wbWe,
    input  mipsPkg::dataWord wbAdr,
    input  mipsPkg::dataWord wbDatO,
    input  logic [3:0]       wbSel,
    output mipsPkg::dataWord wbDatI,
    output logic             wbAck
);

    localparam int wordCount = 256;

    mipsPkg::dataWord memory [wordCount];
    integer           seed = 12;
    logic [7:0]       wordIdx;
    logic [1:0]       waitLeft;
    logic [1:0]       remaining;
    logic             inCycle;

    assign wordIdx = wbAdr[9:2];

    always @(posedge CLK) begin
        if (reset) begin
            wbAck    <= 1'b0;
            inCycle  <= 1'b0;
            waitLeft <= '0;
            // Fill pattern carries the byte address
            for (int i = 0; i < wordCount; i++) begin
                memory[i] <= 32'hA5A5_0000 ^ mipsPkg::dataWord'(i << 2);
            end
        end else begin
            wbAck <= 1'b0;
            if (wbCyc && wbStb && !wbAck) begin
                // New request draws 0 to 3 wait cycles
                if (inCycle) begin
                    remaining = waitLeft;
                end else begin
                    remaining = 2'($unsigned($random(seed)) % 4);
                end
                if (remaining == 2'd0) begin
                    wbAck   <= 1'b1;
                    inCycle <= 1'b0;
                    wbDatI  <= memory[wordIdx];
                    if (wbWe && wbSel == 4'b1111) begin
                        memory[wordIdx] <= wbDatO;
                    end
                end else begin
                    inCycle  <= 1'b1;
                    waitLeft <= remaining - 2'd1;
                end
            end
        end
    end

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic              CLK,
    input  logic              reset,
    input  logic              instrValid,
    input  mipsPkg::instrWord instr,
    output logic              instrReady,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output mipsPkg::dataWord  wbAdr,
    output mipsPkg::dataWord  wbDatO,
    output logic [3:0]        wbSel,
    input  mipsPkg::dataWord  wbDatI,
    input  logic              wbAck,
    output logic              retireValid,
    output mipsPkg::regIndex  retireReg,
    output mipsPkg::dataWord  retireData
);

    // ------------------------------
    // Stage links
    // ------------------------------
    mipsPkg::decodeBundle  issue;
    mipsPkg::executeBundle executed;
    mipsPkg::retireBundle  retire;
    logic                  advance;
    logic                  stall;

    mipsDecode mipsDecode_inst (
        .CLK        (CLK),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .advance    (advance),
        .retire     (retire),
        .issue      (issue)
    );

    mipsExecute mipsExecute_inst (
        .CLK      (CLK),
        .reset    (reset),
        .issue    (issue),
        .stall    (stall),
        .advance  (advance),
        .executed (executed)
    );

    mipsResult mipsResult_inst (
        .CLK      (CLK),
        .reset    (reset),
        .executed (executed),
        .stall    (stall),
        .retire   (retire),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatO   (wbDatO),
        .wbSel    (wbSel),
        .wbDatI   (wbDatI),
        .wbAck    (wbAck)
    );

    // Retire report out to the pins
    assign retireValid = retire.valid;
    assign retireReg   = retire.destReg;
    assign retireData  = retire.value;

endmodule

//--- verilog/mipsDecode.sv
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mipsDecode (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 instrValid,
    input  mipsPkg::instrWord    instr,
    output logic                 instrReady,
    input  logic                 advance,
    input  mipsPkg::retireBundle retire,
    output mipsPkg::decodeBundle issue
);

    // Instruction fields
    logic [5:0]            opcode;
    logic [5:0]            funct;
    mipsPkg::regIndex      rsIdx;
    mipsPkg::regIndex      rtIdx;
    mipsPkg::regIndex      rdIdx;
    mipsPkg::shiftAmount   shamt;
    logic [15:0]           imm;

    mipsPkg::dataWord      regFile [`REG_COUNT];
    logic [`REG_COUNT-1:0] pending;
    logic [`REG_COUNT-1:0] pendingNext;

    mipsPkg::aluOp         op;
    mipsPkg::memAccess     mem;
    mipsPkg::regIndex      destIdx;
    logic                  usesRs;
    logic                  usesRt;
    logic                  useImm;
    logic                  zeroExt;
    logic                  writesRaw;
    logic                  writes;
    mipsPkg::dataWord      rsValue;
    mipsPkg::dataWord      rtValue;
    mipsPkg::dataWord      immValue;
    logic                  hazard;
    logic                  accept;
    mipsPkg::decodeBundle  nextIssue;

    assign opcode = instr[31:26];
    assign rsIdx  = instr[25:21];
    assign rtIdx  = instr[20:16];
    assign rdIdx  = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    // Write before read, so a retiring value is visible this cycle
    function automatic mipsPkg::dataWord readReg(mipsPkg::regIndex idx);
        if (idx == '0) begin
            return '0;
        end
        if (retire.valid && retire.destReg == idx) begin
            return retire.value;
        end
        return regFile[idx];
    endfunction

    function automatic logic isBusy(mipsPkg::regIndex idx);
        return pending[idx] && !(retire.valid && retire.destReg == idx);
    endfunction

    // ------------------------------
    // Opcode decode
    // ------------------------------
    always_comb begin
        op        = mipsPkg::opAdd;
        mem       = mipsPkg::memNone;
        destIdx   = rtIdx;
        usesRs    = 1'b1;
        usesRt    = 1'b0;
        useImm    = 1'b1;
        zeroExt   = 1'b0;
        writesRaw = 1'b1;
        case (opcode)
            6'h00: begin
                destIdx = rdIdx;
                usesRt  = 1'b1;
                useImm  = 1'b0;
                case (funct)
                    6'h21: op = mipsPkg::opAdd;
                    6'h23: op = mipsPkg::opSub;
                    6'h24: op = mipsPkg::opAnd;
                    6'h25: op = mipsPkg::opOr;
                    6'h26: op = mipsPkg::opXor;
                    6'h2a: op = mipsPkg::opSlt;
                    6'h00: begin
                        op     = mipsPkg::opSll;
                        usesRs = 1'b0;
                    end
                    6'h02: begin
                        op     = mipsPkg::opSrl;
                        usesRs = 1'b0;
                    end
                    default: writesRaw = 1'b0;
                endcase
            end
            6'h09: op = mipsPkg::opAdd;
            6'h0d: begin
                op      = mipsPkg::opOr;
                zeroExt = 1'b1;
            end
            6'h0f: begin
                op      = mipsPkg::opLui;
                usesRs  = 1'b0;
                zeroExt = 1'b1;
            end
            6'h23: mem = mipsPkg::memLoad;
            6'h2b: begin
                mem       = mipsPkg::memStore;
                usesRt    = 1'b1;
                writesRaw = 1'b0;
            end
            // Unknown opcodes pass through as bubbles with no write
            default: begin
                usesRs    = 1'b0;
                writesRaw = 1'b0;
            end
        endcase
    end

    assign writes   = writesRaw && (destIdx != '0);
    assign immValue = zeroExt ? {{(`DATA_WIDTH-16){1'b0}}, imm}
                              : {{(`DATA_WIDTH-16){imm[15]}}, imm};

    always_comb begin
        rsValue = readReg(rsIdx);
        rtValue = readReg(rtIdx);
    end

    // WAW is blocked too, so one pending bit per register is enough
    always_comb begin
        hazard = (usesRs && isBusy(rsIdx)) || (usesRt && isBusy(rtIdx))
              || (writes && isBusy(destIdx));
    end

    assign instrReady = advance && !hazard;
    assign accept     = instrValid && instrReady;

    always_comb begin
        nextIssue.valid     = accept;
        nextIssue.aluOp     = op;
        nextIssue.operandA  = rsValue;
        nextIssue.operandB  = useImm ? immValue : rtValue;
        nextIssue.shamt     = shamt;
        nextIssue.storeData = rtValue;
        nextIssue.memAccess = mem;
        nextIssue.destReg   = destIdx;
        nextIssue.writesReg = writes;
    end

    // ------------------------------
    // Scoreboard and register file
    // ------------------------------
    always_comb begin
        pendingNext = pending;
        if (retire.valid) begin
            pendingNext[retire.destReg] = 1'b0;
        end
        if (accept && writes) begin
            pendingNext[destIdx] = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
            pending <= '0;
        end else begin
            if (retire.valid) begin
                regFile[retire.destReg] <= retire.value;
            end
            pending <= pendingNext;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (advance) begin
            issue <= nextIssue;
        end
    end

    // Source of an accepted instruction is not the target still waiting in issue
    assert property (@(posedge CLK) disable iff (reset)
        accept && usesRs |-> !(issue.valid && issue.writesReg && issue.destReg == rsIdx));
    assert property (@(posedge CLK) disable iff (reset)
        accept && usesRt |-> !(issue.valid && issue.writesReg && issue.destReg == rtIdx));

endmodule

//--- verilog/mipsDefines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ------------------------------
// Core widths and depths
// ------------------------------

// Word width of registers, ALU and data bus
`define DATA_WIDTH 32

// General purpose registers, r0 included
`define REG_COUNT 32

// Bits needed to name one register
`define REG_INDEX_WIDTH 5

`endif

//--- verilog/mipsExecute.sv
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mipsExecute (
    input  logic                  CLK,
    input  logic                  reset,
    input  mipsPkg::decodeBundle  issue,
    input  logic                  stall,
    output logic                  advance,
    output mipsPkg::executeBundle executed
);

    mipsPkg::dataWord      sum;
    mipsPkg::dataWord      result;
    mipsPkg::executeBundle nextExecuted;

    assign sum = issue.operandA + issue.operandB;

    // ------------------------------
    // ALU and shifter
    // ------------------------------
    always_comb begin
        case (issue.aluOp)
            mipsPkg::opAdd: result = sum;
            mipsPkg::opSub: result = issue.operandA - issue.operandB;
            mipsPkg::opAnd: result = issue.operandA & issue.operandB;
            mipsPkg::opOr:  result = issue.operandA | issue.operandB;
            mipsPkg::opXor: result = issue.operandA ^ issue.operandB;
            // Signed compare
            mipsPkg::opSlt: result = mipsPkg::dataWord'($signed(issue.operandA)
                                                       < $signed(issue.operandB));
            mipsPkg::opSll: result = issue.operandB << issue.shamt;
            mipsPkg::opSrl: result = issue.operandB >> issue.shamt;
            mipsPkg::opLui: result = issue.operandB << (`DATA_WIDTH / 2);
            default:        result = sum;
        endcase
    end

    always_comb begin
        nextExecuted.valid     = issue.valid;
        nextExecuted.aluResult = (issue.memAccess != mipsPkg::memNone) ? sum : result;
        nextExecuted.storeData = issue.storeData;
        nextExecuted.memAccess = issue.memAccess;
        nextExecuted.destReg   = issue.destReg;
        nextExecuted.writesReg = issue.writesReg;
    end

    assign advance = !stall;

    // Held while the result stage is on the bus
    always_ff @(posedge CLK) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else if (!stall) begin
            executed <= nextExecuted;
        end
    end

endmodule

//--- verilog/mipsPkg.sv
`include "mipsDefines.svh"

package mipsPkg;

    // ------------------------------
    // Plain vector types
    // ------------------------------
    typedef logic [`DATA_WIDTH-1:0] dataWord;
    typedef logic [`DATA_WIDTH-1:0] instrWord;
    typedef logic [`REG_INDEX_WIDTH-1:0] regIndex;
    typedef logic [`REG_INDEX_WIDTH-1:0] shiftAmount;

    // ALU function selected in decode
    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opSll,
        opSrl,
        opLui
    } aluOp;

    typedef enum logic [1:0] {
        memNone,
        memLoad,
        memStore
    } memAccess;

    // Result stage FSM
    typedef enum logic {
        stIdle,
        stBus
    } resultState;

    // ------------------------------
    // Stage bundles
    // ------------------------------
    typedef struct packed {
        logic       valid;
        aluOp       aluOp;
        dataWord    operandA;
        dataWord    operandB;
        shiftAmount shamt;
        dataWord    storeData;
        memAccess   memAccess;
        regIndex    destReg;
        logic       writesReg;
    } decodeBundle;

    // aluResult doubles as the address of loads and stores
    typedef struct packed {
        logic     valid;
        dataWord  aluResult;
        dataWord  storeData;
        memAccess memAccess;
        regIndex  destReg;
        logic     writesReg;
    } executeBundle;

    typedef struct packed {
        logic    valid;
        regIndex destReg;
        dataWord value;
    } retireBundle;

endpackage

//--- verilog/mipsResult.sv
`timescale 1ns/1ps

module mipsResult (
    input  logic                  CLK,
    input  logic                  reset,
    input  mipsPkg::executeBundle executed,
    output logic                  stall,
    output mipsPkg::retireBundle  retire,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output mipsPkg::dataWord      wbAdr,
    output mipsPkg::dataWord      wbDatO,
    output logic [3:0]            wbSel,
    input  mipsPkg::dataWord      wbDatI,
    input  logic                  wbAck
);

    mipsPkg::resultState state;
    mipsPkg::regIndex    loadDest;
    logic                loadWrites;

    // One bus cycle per state visit, word accesses only
    assign wbCyc = (state == mipsPkg::stBus);
    assign wbStb = wbCyc;
    assign wbSel = 4'b1111;
    assign stall = wbCyc;

    // ------------------------------
    // Bus FSM and writeback
    // ------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            state        <= mipsPkg::stIdle;
            wbWe         <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= 1'b0;
            case (state)
                mipsPkg::stIdle: begin
                    if (executed.valid && executed.memAccess != mipsPkg::memNone) begin
                        state      <= mipsPkg::stBus;
                        wbWe       <= (executed.memAccess == mipsPkg::memStore);
                        wbAdr      <= executed.aluResult;
                        wbDatO     <= executed.storeData;
                        loadDest   <= executed.destReg;
                        loadWrites <= (executed.memAccess == mipsPkg::memLoad)
                                   && executed.writesReg && (executed.destReg != '0);
                    end else if (executed.valid && executed.writesReg
                                 && executed.destReg != '0) begin
                        retire.valid   <= 1'b1;
                        retire.destReg <= executed.destReg;
                        retire.value   <= executed.aluResult;
                    end
                end
                mipsPkg::stBus: begin
                    // Load data retires on the acknowledge edge
                    if (wbAck) begin
                        state          <= mipsPkg::stIdle;
                        wbWe           <= 1'b0;
                        retire.valid   <= loadWrites;
                        retire.destReg <= loadDest;
                        retire.value   <= wbDatI;
                    end
                end
                default: state <= mipsPkg::stIdle;
            endcase
        end
    end

    // Acknowledge only answers a strobed cycle
    assert property (@(posedge CLK) disable iff (reset)
        wbAck |-> wbCyc && wbStb);

    assert property (@(posedge CLK) disable iff (reset)
        retire.valid |-> retire.destReg != '0);

endmodule
